// File: source/rename_config_pkg.sv
/* rename sizing constants */

package rename_config_pkg;

	//////////////////////////////////////////////////
	// register file sizes
	//////////////////////////////////////////////////

	localparam int arf_size = 32;	// architectural regs
	localparam int prf_size = 64;	// physical regs

	localparam int arf_idx_w = $clog2(arf_size);	// 5 bits
	localparam int prf_tag_w = $clog2(prf_size);	// 6 bits

	//////////////////////////////////////////////////
	// index and tag types
	//////////////////////////////////////////////////

	typedef logic [arf_idx_w-1:0] arf_idx_t;	// arch register index
	typedef logic [prf_tag_w-1:0] prf_tag_t;	// physical tag

endpackage

// File: source/rename_types_pkg.sv
/* rename stage interface types */

package rename_types_pkg;

	//////////////////////////////////////////////////
	// instruction into rename
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                         valid;	// held as a level through a halt
		rename_config_pkg::arf_idx_t  opa_idx;	// source a
		rename_config_pkg::arf_idx_t  opb_idx;	// source b
		logic                         opa_imm;	// source a is an immediate
		logic                         opb_imm;	// source b is an immediate
		logic                         has_dest;	// needs a new tag
		rename_config_pkg::arf_idx_t  dest_idx;	// destination reg
	} rename_req_t;

	// renamed instruction out
	typedef struct packed {
		logic                         valid;
		rename_config_pkg::prf_tag_t  opa_tag;	// 0 for immediates
		rename_config_pkg::prf_tag_t  opb_tag;
		logic                         opa_imm;	// passed through
		logic                         opb_imm;
		rename_config_pkg::prf_tag_t  dest_tag;	// freshly allocated
		rename_config_pkg::prf_tag_t  old_tag;	// mapping being replaced
	} rename_resp_t;

	// retiring instruction
	typedef struct packed {
		logic                         valid;	// single cycle strobe
		rename_config_pkg::arf_idx_t  arf_idx;
		rename_config_pkg::prf_tag_t  prf_tag;	// committed mapping
		rename_config_pkg::prf_tag_t  old_tag;	// tag to free
	} commit_t;

	// what the speculative table does this cycle
	typedef enum logic [1:0] {
		rat_idle    = 2'd0,
		rat_rename  = 2'd1,
		rat_stall   = 2'd2,
		rat_recover = 2'd3
	} rat_op_e;

endpackage

// File: source/rat.sv
/* speculative register alias table */

`timescale 1ns/100ps

module rat (
	input  logic                                  clock,
	input  logic                                  reset,
	input  rename_types_pkg::rename_req_t         req,
	input  logic                                  mispredict,
	input  rename_config_pkg::prf_tag_t [rename_config_pkg::arf_size-1:0] arch_table,
	input  rename_config_pkg::prf_tag_t           alloc_tag,	// lowest free tag
	input  logic                                  alloc_ok,	// free list not empty
	output rename_types_pkg::rename_resp_t        resp,
	output logic                                  halt,
	output logic                                  alloc_take	// pop the free list
);

	rename_config_pkg::prf_tag_t [rename_config_pkg::arf_size-1:0] map_q;	// spec map
	rename_types_pkg::rat_op_e op;	// this cycle's action

	//////////////////////////////////////////////////
	// operation decode
	//////////////////////////////////////////////////

	always_comb begin
		if (mispredict) begin
			op = rename_types_pkg::rat_recover;	// wins over everything
		end else if (!req.valid) begin
			op = rename_types_pkg::rat_idle;
		end else if (req.has_dest && !alloc_ok) begin
			op = rename_types_pkg::rat_stall;	// no tag to hand out
		end else begin
			op = rename_types_pkg::rat_rename;
		end
	end

	//////////////////////////////////////////////////
	// lookup and response
	//////////////////////////////////////////////////

	always_comb begin
		resp       = '0;
		halt       = 1'b0;
		alloc_take = 1'b0;
		case (op)
			rename_types_pkg::rat_rename: begin
				resp.valid   = 1'b1;
				resp.opa_imm = req.opa_imm;	// flags go straight through
				resp.opb_imm = req.opb_imm;
				// sources see the map before this instruction's write
				resp.opa_tag = req.opa_imm ? '0 : map_q[req.opa_idx];
				resp.opb_tag = req.opb_imm ? '0 : map_q[req.opb_idx];
				if (req.has_dest) begin
					resp.dest_tag = alloc_tag;	// new physical home
					resp.old_tag  = map_q[req.dest_idx];	// freed at retire
					alloc_take    = 1'b1;
				end
			end
			rename_types_pkg::rat_stall: begin
				halt = 1'b1;	// requester holds req
			end
			default: begin
				// idle and recover leave resp cleared
			end
		endcase
	end

	//////////////////////////////////////////////////
	// table update
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_config_pkg::arf_size; i++) begin
				map_q[i] <= rename_config_pkg::prf_tag_t'(i);	// identity map
			end
		end else begin
			case (op)
				rename_types_pkg::rat_recover: begin
					map_q <= arch_table;	// back to committed state
				end
				rename_types_pkg::rat_rename: begin
					if (req.has_dest) begin
						map_q[req.dest_idx] <= alloc_tag;
					end
				end
				default: begin
					map_q <= map_q;	// idle or stall holds
				end
			endcase
		end
	end

endmodule

// File: source/rrat.sv
/* retirement alias table */

`timescale 1ns/100ps

module rrat (
	input  logic                                  clock,
	input  logic                                  reset,
	input  rename_types_pkg::commit_t             commit,
	output rename_config_pkg::prf_tag_t [rename_config_pkg::arf_size-1:0] arch_table,
	output logic [rename_config_pkg::prf_size-1:0] arch_in_use	// tags the map holds
);

	rename_config_pkg::prf_tag_t [rename_config_pkg::arf_size-1:0] map_q;	// committed map
	logic [rename_config_pkg::prf_size-1:0] in_use_q;	// one bit per tag
	rename_config_pkg::prf_tag_t prev_tag;	// entry being overwritten

	// current holder of the retiring register
	assign prev_tag = map_q[commit.arf_idx];

	//////////////////////////////////////////////////
	// committed map
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_config_pkg::arf_size; i++) begin
				map_q[i] <= rename_config_pkg::prf_tag_t'(i);	// reg i on tag i
			end
		end else if (commit.valid) begin
			map_q[commit.arf_idx] <= commit.prf_tag;
		end
	end

	//////////////////////////////////////////////////
	// in-use bitmap
	//////////////////////////////////////////////////

	// tracks exactly what map_q references, so a rebuild on mispredict
	// also recovers tags renamed and overwritten on the wrong path
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_config_pkg::prf_size; i++) begin
				in_use_q[i] <= (i < rename_config_pkg::arf_size);	// low half busy
			end
		end else if (commit.valid) begin
			in_use_q[prev_tag]       <= 1'b0;	// old mapping gone
			in_use_q[commit.prf_tag] <= 1'b1;	// new one takes its place
		end
	end

	assign arch_table  = map_q;
	assign arch_in_use = in_use_q;

endmodule

// File: source/prf_free_list.sv
/* physical register free list */

`timescale 1ns/100ps

module prf_free_list (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   alloc_take,	// rat used alloc_tag
	input  rename_types_pkg::commit_t              commit,
	input  logic                                   mispredict,
	input  logic [rename_config_pkg::prf_size-1:0] arch_in_use,
	output rename_config_pkg::prf_tag_t            alloc_tag,
	output logic                                   alloc_ok
);

	logic [rename_config_pkg::prf_size-1:0] free_q;	// 1 means free
	logic [rename_config_pkg::prf_size-1:0] free_next;

	//////////////////////////////////////////////////
	// lowest free select
	//////////////////////////////////////////////////

	// scan from the top so the lowest set bit is written last
	always_comb begin
		alloc_tag = '0;
		alloc_ok  = 1'b0;
		for (int i = rename_config_pkg::prf_size - 1; i >= 0; i--) begin
			if (free_q[i]) begin
				alloc_tag = rename_config_pkg::prf_tag_t'(i);
				alloc_ok  = 1'b1;	// at least one free
			end
		end
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb begin
		if (mispredict) begin
			free_next = ~arch_in_use;	// rebuild from committed map
		end else begin
			free_next = free_q;
			if (alloc_take) begin
				free_next[alloc_tag] = 1'b0;	// handed to rat
			end
			if (commit.valid) begin
				free_next[commit.old_tag] = 1'b1;	// retired overwrite
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rename_config_pkg::prf_size; i++) begin
				free_q[i] <= (i >= rename_config_pkg::arf_size);	// upper half free
			end
		end else begin
			free_q <= free_next;
		end
	end

endmodule

// File: source/rename_unit.sv
/* register rename stage top */

`timescale 1ns/100ps

module rename_unit (
	input  logic                           clock,
	input  logic                           reset,
	input  rename_types_pkg::rename_req_t  req,
	input  rename_types_pkg::commit_t      commit,
	input  logic                           mispredict,
	output rename_types_pkg::rename_resp_t resp,
	output logic                           halt
);

	rename_config_pkg::prf_tag_t alloc_tag;	// free list to rat
	logic                        alloc_ok;
	logic                        alloc_take;	// rat back to free list
	rename_config_pkg::prf_tag_t [rename_config_pkg::arf_size-1:0] arch_table;
	logic [rename_config_pkg::prf_size-1:0] arch_in_use;	// rrat to free list

	//////////////////////////////////////////////////
	// speculative map
	//////////////////////////////////////////////////

	rat u_rat (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.mispredict (mispredict),
		.arch_table (arch_table),
		.alloc_tag  (alloc_tag),
		.alloc_ok   (alloc_ok),
		.resp       (resp),
		.halt       (halt),
		.alloc_take (alloc_take)
	);

	// committed map
	rrat u_rrat (
		.clock       (clock),
		.reset       (reset),
		.commit      (commit),
		.arch_table  (arch_table),
		.arch_in_use (arch_in_use)
	);

	// tag allocator
	prf_free_list u_free_list (
		.clock       (clock),
		.reset       (reset),
		.alloc_take  (alloc_take),
		.commit      (commit),
		.mispredict  (mispredict),
		.arch_in_use (arch_in_use),
		.alloc_tag   (alloc_tag),
		.alloc_ok    (alloc_ok)
	);

endmodule

// File: tests/rename_unit_tb.sv
/* rename stage testbench */

`timescale 1ns/100ps

module rename_unit_tb;

	localparam int max_cycles = 1000;	// tests need about 110

	logic                           clock = 1'b0;
	logic                           reset;
	rename_types_pkg::rename_req_t  req;
	rename_types_pkg::commit_t      commit;
	logic                           mispredict;
	rename_types_pkg::rename_resp_t resp;
	logic                           halt;

	// reference model
	rename_config_pkg::prf_tag_t spec_map [rename_config_pkg::arf_size];
	rename_config_pkg::prf_tag_t comm_map [rename_config_pkg::arf_size];
	logic [rename_config_pkg::prf_size-1:0] free_bm;	// 1 means free
	rename_types_pkg::commit_t pending [$];	// renamed, not yet retired

	int cycle_count  = 0;
	int error_count  = 0;
	int tests_run    = 0;
	int tests_failed = 0;

	rename_unit u_dut (
		.clock      (clock),
		.reset      (reset),
		.req        (req),
		.commit     (commit),
		.mispredict (mispredict),
		.resp       (resp),
		.halt       (halt)
	);

	always #50 clock = ~clock;	// 100 ns period

	// hang guard
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// checks and helpers
	//////////////////////////////////////////////////

	task automatic check_resp(input string name,
		input rename_types_pkg::rename_resp_t expected,
		input rename_types_pkg::rename_resp_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: resp expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_halt(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: halt expected %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	function automatic int lowest_free();
		for (int i = 0; i < rename_config_pkg::prf_size; i++) begin
			if (free_bm[i]) return i;	// first set bit
		end
		return -1;	// list empty
	endfunction

	function automatic int rnd_idx();
		return int'($urandom % rename_config_pkg::arf_size);
	endfunction

	function automatic rename_types_pkg::rename_req_t make_req(input int opa, input int opb,
		input logic opa_imm, input logic opb_imm, input logic has_dest, input int dest);
		rename_types_pkg::rename_req_t r;
		r.valid    = 1'b1;
		r.opa_idx  = rename_config_pkg::arf_idx_t'(opa);
		r.opb_idx  = rename_config_pkg::arf_idx_t'(opb);
		r.opa_imm  = opa_imm;
		r.opb_imm  = opb_imm;
		r.has_dest = has_dest;
		r.dest_idx = rename_config_pkg::arf_idx_t'(dest);
		return r;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < rename_config_pkg::arf_size; i++) begin
			spec_map[i] = rename_config_pkg::prf_tag_t'(i);	// identity
			comm_map[i] = rename_config_pkg::prf_tag_t'(i);
		end
		for (int i = 0; i < rename_config_pkg::prf_size; i++) begin
			free_bm[i] = (i >= rename_config_pkg::arf_size);	// upper half free
		end
		pending.delete();
	endtask

	// drives one cycle, checks the same-cycle response and advances the model
	task automatic step(input string name, input rename_types_pkg::rename_req_t r,
		input rename_types_pkg::commit_t c, input logic mp);
		rename_types_pkg::rename_resp_t exp_resp;
		rename_types_pkg::commit_t      entry;
		logic                           exp_halt;
		int                             low;
		low      = lowest_free();
		exp_resp = '0;
		exp_halt = 1'b0;
		@(negedge clock);
		req        = r;
		commit     = c;
		mispredict = mp;
		if (!mp && r.valid) begin
			if (r.has_dest && low < 0) begin
				exp_halt = 1'b1;	// no tag left
			end else begin
				exp_resp.valid   = 1'b1;
				exp_resp.opa_imm = r.opa_imm;
				exp_resp.opb_imm = r.opb_imm;
				exp_resp.opa_tag = r.opa_imm ? '0 : spec_map[r.opa_idx];	// pre-write view
				exp_resp.opb_tag = r.opb_imm ? '0 : spec_map[r.opb_idx];
				if (r.has_dest) begin
					exp_resp.dest_tag = rename_config_pkg::prf_tag_t'(low);
					exp_resp.old_tag  = spec_map[r.dest_idx];
				end
			end
		end
		#10;	// lookup settles
		check_resp(name, exp_resp, resp);
		check_halt(name, exp_halt, halt);
		if (mp) begin
			spec_map = comm_map;	// back to committed view
			free_bm  = '1;
			foreach (comm_map[i]) free_bm[comm_map[i]] = 1'b0;
			pending.delete();	// wrong path squashed
		end else begin
			if (exp_resp.valid && r.has_dest) begin
				spec_map[r.dest_idx]       = exp_resp.dest_tag;
				free_bm[exp_resp.dest_tag] = 1'b0;
				entry.valid   = 1'b1;
				entry.arf_idx = r.dest_idx;
				entry.prf_tag = exp_resp.dest_tag;
				entry.old_tag = exp_resp.old_tag;
				pending.push_back(entry);	// retire later in order
			end
			if (c.valid) begin
				comm_map[c.arf_idx] = c.prf_tag;
				free_bm[c.old_tag]  = 1'b1;	// usable the cycle after
			end
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_mapping();
		int errs;
		errs = error_count;
		for (int i = 0; i < 8; i++) begin
			step("reset_mapping", make_req(rnd_idx(), rnd_idx(), 0, 0, 0, 0), '0, 1'b0);
		end
		finish_test("reset_mapping", errs);
	endtask

	task automatic test_rename_chain();
		int errs;
		errs = error_count;
		step("rename_chain", make_req(5, 6, 0, 0, 1, 5), '0, 1'b0);	// own source sees old
		step("rename_chain", make_req(5, 5, 0, 0, 1, 5), '0, 1'b0);	// old is 32 now
		step("rename_chain", make_req(5, 6, 0, 0, 0, 0), '0, 1'b0);	// reads newest
		finish_test("rename_chain", errs);
	endtask

	task automatic test_immediates();
		int errs;
		errs = error_count;
		step("immediates", make_req(5, 6, 1, 0, 0, 0), '0, 1'b0);
		step("immediates", make_req(5, 6, 0, 1, 1, 7), '0, 1'b0);
		step("immediates", make_req(1, 2, 1, 1, 0, 0), '0, 1'b0);
		finish_test("immediates", errs);
	endtask

	task automatic test_exhaustion();
		rename_types_pkg::rename_req_t stalled;
		int errs;
		errs = error_count;
		while (free_bm != '0) begin
			step("exhaustion", make_req(rnd_idx(), rnd_idx(), 0, 0, 1, rnd_idx()), '0, 1'b0);
		end
		stalled = make_req(3, 4, 0, 0, 1, 9);
		step("exhaustion", stalled, '0, 1'b0);	// halt
		step("exhaustion", stalled, '0, 1'b0);	// still held
		step("exhaustion", make_req(9, 3, 0, 0, 0, 0), '0, 1'b0);	// map unchanged
		finish_test("exhaustion", errs);
	endtask

	task automatic test_commit_release();
		rename_types_pkg::commit_t c;
		int errs;
		errs = error_count;
		c = pending.pop_front();	// oldest rename
		step("commit_release", '0, c, 1'b0);
		step("commit_release", make_req(1, 2, 0, 0, 1, 12), '0, 1'b0);	// gets freed tag
		finish_test("commit_release", errs);
	endtask

	task automatic test_mispredict();
		rename_types_pkg::commit_t c;
		int errs;
		errs = error_count;
		for (int i = 0; i < 2; i++) begin
			c = pending.pop_front();
			step("mispredict", '0, c, 1'b0);
		end
		step("mispredict", make_req(1, 2, 0, 0, 1, 3), '0, 1'b1);	// recovery wins
		for (int i = 0; i < 16; i++) begin
			step("mispredict", make_req(i, i + 16, 0, 0, 0, 0), '0, 1'b0);	// whole map
		end
		// drains the rebuilt list, wrong-path overwrites included
		while (free_bm != '0) begin
			step("mispredict", make_req(rnd_idx(), rnd_idx(), 0, 0, 1, rnd_idx()), '0, 1'b0);
		end
		finish_test("mispredict", errs);
	endtask

	//////////////////////////////////////////////////
	// run
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hab77_011e));	// fixed seed
		reset      = 1'b1;
		req        = '0;
		commit     = '0;
		mispredict = 1'b0;
		model_reset();
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		test_reset_mapping();
		test_rename_chain();
		test_immediates();
		test_exhaustion();
		test_commit_release();
		test_mispredict();
		@(negedge clock);
		req = '0;	// back to idle
		$display("%0d run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: list.f
source/rename_config_pkg.sv
source/rename_types_pkg.sv
source/rat.sv
source/rrat.sv
source/prf_free_list.sv
source/rename_unit.sv
tests/rename_unit_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = rename_unit_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
PASS_MSG = all tests passed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
